//--- include/exception_cause.svh
`ifndef EXCEPTION_CAUSE_SVH
`define EXCEPTION_CAUSE_SVH

// Internal 2-bit cause codes carried between the trap stages
// Zero means nothing was raised

// No exception
`define NOT_EXCEPTION       2'd0
// Fetch from a misaligned address
`define I_ADDR_MISALIGNMENT 2'd1
// Undecodable instruction word
`define ILLEGAL_IR          2'd2
// Environment call from machine mode
`define ECALL               2'd3

`endif

//--- hdl/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // Machine word width
    localparam int XLEN = 32;

    // Major opcodes of the RV32I base set
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE  = 7'b0100011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

    // funct7 values seen in the base set
    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    // SUB and SRA / SRAI
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

    // funct3 codes that decide how funct7 is checked
    localparam logic [2:0] FUNCT3_SLL = 3'b001;
    localparam logic [2:0] FUNCT3_SRL = 3'b101;
    localparam logic [2:0] FUNCT3_ADD = 3'b000;

    // Complete SYSTEM words recognised by this core
    localparam logic [XLEN-1:0] INSTR_ECALL = 32'h0000_0073;
    localparam logic [XLEN-1:0] INSTR_MRET  = 32'h3020_0073;

    // Exception codes written to mcause (interrupt bit clear)
    localparam logic [XLEN-1:0] MCAUSE_INSTR_MISALIGNED = 32'd0;
    localparam logic [XLEN-1:0] MCAUSE_ILLEGAL          = 32'd2;
    localparam logic [XLEN-1:0] MCAUSE_ECALL_M          = 32'd11;

endpackage

`default_nettype wire

//--- hdl/trap_pkg.sv
`default_nettype none

package trap_pkg;

    import rv_pkg::*;

    `include "exception_cause.svh"

    // Internal cause code as defined in exception_cause.svh
    typedef logic [1:0] cause_t;

    // One decoded instruction from the ID side
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] ir;
        logic            i_addr_misaligned;
        // Resolved later and annuls this instruction
        logic            jump;
    } id_instr_t;

    // Classified instruction on its way into the CSR block
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic            raised;
        cause_t          cause;
        logic [XLEN-1:0] epc;
        logic [XLEN-1:0] tval;
        logic            is_mret;
    } trap_rec_t;

    // Result record handed back to the core
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic            raised;
        cause_t          cause;
        logic            redirect;
        logic [XLEN-1:0] target;
    } trap_out_t;

    // Visible machine trap registers
    typedef struct packed {
        logic [XLEN-1:0] mepc;
        logic [XLEN-1:0] mcause;
        logic [XLEN-1:0] mtval;
        logic [XLEN-1:0] mtvec;
    } trap_state_t;

    // mtvec configuration write
    typedef struct packed {
        logic            en;
        logic [XLEN-1:0] data;
    } cfg_wr_t;

    // Internal cause to architectural mcause value
    function automatic logic [XLEN-1:0] cause_to_mcause(input cause_t cause);
        case (cause)
            `I_ADDR_MISALIGNMENT: return MCAUSE_INSTR_MISALIGNED;
            `ILLEGAL_IR:          return MCAUSE_ILLEGAL;
            `ECALL:               return MCAUSE_ECALL_M;
            default:              return '0;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- hdl/pipe_reg.sv
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  wire logic clk,
    input  wire logic rst,

    // Upstream side
    input  wire logic in_valid,
    output logic      in_ready,
    input  payload_t  in_data,

    // Downstream side
    output logic      out_valid,
    input  wire logic out_ready,
    output payload_t  out_data
);

    logic     full;
    payload_t data_q;

    // Accept when empty, or when the held item leaves this cycle
    assign in_ready = !full || out_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            full <= 1'b0;
        end
        else if (in_valid && in_ready)
        begin
            full <= 1'b1;
        end
        else if (out_ready)
        begin
            // Held item taken with nothing new arriving
            full <= 1'b0;
        end
    end

    // Payload only moves on an accepted input
    always_ff @(posedge clk)
    begin
        if (in_valid && in_ready)
        begin
            data_q <= in_data;
        end
    end

    assign out_valid = full;
    assign out_data  = data_q;

endmodule

`default_nettype wire

//--- hdl/instr_classifier.sv
`default_nettype none

module instr_classifier
    import rv_pkg::*;
(
    input  wire logic [XLEN-1:0] ir,
    output logic                 is_illegal_ir,
    output logic                 is_ecall,
    output logic                 is_mret
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       legal;

    // Fixed RV32 field positions
    assign opcode = ir[6:0];
    assign funct3 = ir[14:12];
    assign funct7 = ir[31:25];

    // Exact-word matches for the supported SYSTEM instructions
    assign is_ecall = (ir == INSTR_ECALL);
    assign is_mret  = (ir == INSTR_MRET);

    always_comb
    begin
        case (opcode)
            // U and J types have no funct fields
            OPCODE_LUI, OPCODE_AUIPC, OPCODE_JAL:
                legal = 1'b1;
            OPCODE_JALR:
                legal = (funct3 == 3'b000);
            // funct3 2 and 3 are reserved for branches
            OPCODE_BRANCH:
                legal = (funct3 != 3'b010) && (funct3 != 3'b011);
            // LB LH LW LBU LHU
            OPCODE_LOAD:
                legal = (funct3 != 3'b011) && (funct3 != 3'b110) && (funct3 != 3'b111);
            // SB SH SW
            OPCODE_STORE:
                legal = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b010);
            OPCODE_OP_IMM:
            begin
                // Only the shifts constrain the upper bits
                if (funct3 == FUNCT3_SLL)
                    legal = (funct7 == FUNCT7_BASE);
                else if (funct3 == FUNCT3_SRL)
                    legal = (funct7 == FUNCT7_BASE) || (funct7 == FUNCT7_ALT);
                else
                    legal = 1'b1;
            end
            OPCODE_OP:
            begin
                // Alternate funct7 exists for SUB and SRA only
                if (funct7 == FUNCT7_BASE)
                    legal = 1'b1;
                else if (funct7 == FUNCT7_ALT)
                    legal = (funct3 == FUNCT3_ADD) || (funct3 == FUNCT3_SRL);
                else
                    legal = 1'b0;
            end
            // Anything else under SYSTEM is not implemented
            OPCODE_SYSTEM:
                legal = is_ecall || is_mret;
            // Unknown opcodes, the all-zero word among them
            default:
                legal = 1'b0;
        endcase
    end

    assign is_illegal_ir = !legal;

endmodule

`default_nettype wire

//--- hdl/exception_ctrl.sv
`default_nettype none

`include "exception_cause.svh"

module exception_ctrl
    import rv_pkg::*;
    import trap_pkg::*;
#(
    parameter logic [XLEN-1:0] NO_TRAP_EPC = 32'h0001_0000
) (
    // Instruction in ID
    input  wire logic [XLEN-1:0] pc_in_id,
    input  wire logic [XLEN-1:0] ir_in_id,

    // Candidate causes
    input  wire logic            i_addr_misaligned,
    input  wire logic            is_illegal_ir,
    input  wire logic            is_ecall,
    input  wire logic            jump,

    // Selected exception
    output logic                 e_raised,
    output cause_t               e_cause,
    output logic [XLEN-1:0]      e_pc,
    output logic [XLEN-1:0]      e_tval
);

    // Fixed priority cause selection
    always_comb
    begin
        // Annulled by a taken jump and never executes
        if (jump)
            e_cause = `NOT_EXCEPTION;
        // A misaligned fetch explains a bad word too, so it goes first
        else if (i_addr_misaligned)
            e_cause = `I_ADDR_MISALIGNMENT;
        else if (is_illegal_ir)
            e_cause = `ILLEGAL_IR;
        else if (is_ecall)
            e_cause = `ECALL;
        else
            e_cause = `NOT_EXCEPTION;
    end

    assign e_raised = (e_cause != `NOT_EXCEPTION);

    // Exception PC or a fixed marker when nothing is raised
    assign e_pc = e_raised ? pc_in_id : NO_TRAP_EPC;

    // Trap value depends on the cause
    always_comb
    begin
        case (e_cause)
            `I_ADDR_MISALIGNMENT: e_tval = pc_in_id;
            `ILLEGAL_IR:          e_tval = ir_in_id;
            // ECALL and no exception
            default:              e_tval = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/trap_csr.sv
`default_nettype none

module trap_csr
    import rv_pkg::*;
    import trap_pkg::*;
#(
    parameter logic [XLEN-1:0] MTVEC_RESET = 32'h0000_0100
) (
    input  wire logic clk,
    input  wire logic rst,

    // Classified instruction and its handshake into the output slice
    input  trap_rec_t rec,
    input  wire logic commit,

    // mtvec configuration port
    input  cfg_wr_t   cfg,

    output trap_out_t result,
    output trap_state_t state
);

    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mtval;
    logic [XLEN-1:0] mtvec;

    logic            take_trap;

    // Registers move only when the record is committed
    assign take_trap = commit && rec.raised;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mepc   <= '0;
            mcause <= '0;
            mtval  <= '0;
        end
        else if (take_trap)
        begin
            mepc   <= rec.epc;
            mcause <= cause_to_mcause(rec.cause);
            mtval  <= rec.tval;
        end
    end

    // mtvec is written only from the config port
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mtvec <= MTVEC_RESET;
        end
        else if (cfg.en)
        begin
            mtvec <= cfg.data;
        end
    end

    // Result record built from the registers as they stand now
    always_comb
    begin
        result.pc       = rec.pc;
        result.raised   = rec.raised;
        result.cause    = rec.cause;
        result.redirect = rec.raised || rec.is_mret;
        // A trap wins over MRET
        if (rec.raised)
            result.target = mtvec;
        else if (rec.is_mret)
            result.target = mepc;
        else
            result.target = '0;
    end

    // Visible state
    assign state.mepc   = mepc;
    assign state.mcause = mcause;
    assign state.mtval  = mtval;
    assign state.mtvec  = mtvec;

endmodule

`default_nettype wire

//--- hdl/trap_unit_top.sv
`default_nettype none

module trap_unit_top
    import rv_pkg::*;
    import trap_pkg::*;
#(
    parameter logic [XLEN-1:0] NO_TRAP_EPC = 32'h0001_0000,
    parameter logic [XLEN-1:0] MTVEC_RESET = 32'h0000_0100
) (
    input  wire logic   clk,
    input  wire logic   rst,

    // Decoded instruction stream
    input  wire logic   in_valid,
    output logic        in_ready,
    input  id_instr_t   in_data,

    // Result stream
    output logic        out_valid,
    input  wire logic   out_ready,
    output trap_out_t   out_data,

    input  cfg_wr_t     cfg,
    output trap_state_t csr_state
);

    // Between input slice and CSR block
    logic      id_valid;
    id_instr_t id_instr;
    logic      res_ready;
    logic      commit;

    // Classifier and controller outputs
    logic      is_illegal_ir;
    logic      is_ecall;
    logic      is_mret;
    logic      e_raised;
    cause_t    e_cause;
    logic [XLEN-1:0] e_pc;
    logic [XLEN-1:0] e_tval;

    trap_rec_t rec;
    trap_out_t result;

    pipe_reg #(.payload_t(id_instr_t)) u_in_slice (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (id_valid),
        .out_ready (res_ready),
        .out_data  (id_instr)
    );

    instr_classifier u_instr_classifier (
        .ir            (id_instr.ir),
        .is_illegal_ir (is_illegal_ir),
        .is_ecall      (is_ecall),
        .is_mret       (is_mret)
    );

    exception_ctrl #(.NO_TRAP_EPC(NO_TRAP_EPC)) u_exception_ctrl (
        .pc_in_id          (id_instr.pc),
        .ir_in_id          (id_instr.ir),
        .i_addr_misaligned (id_instr.i_addr_misaligned),
        .is_illegal_ir     (is_illegal_ir),
        .is_ecall          (is_ecall),
        .jump              (id_instr.jump),
        .e_raised          (e_raised),
        .e_cause           (e_cause),
        .e_pc              (e_pc),
        .e_tval            (e_tval)
    );

    // An MRET annulled by a jump must not redirect
    assign rec = '{
        pc:      id_instr.pc,
        raised:  e_raised,
        cause:   e_cause,
        epc:     e_pc,
        tval:    e_tval,
        is_mret: is_mret && !id_instr.jump
    };

    // Handshake into the output slice
    assign commit = id_valid && res_ready;

    trap_csr #(.MTVEC_RESET(MTVEC_RESET)) u_trap_csr (
        .clk    (clk),
        .rst    (rst),
        .rec    (rec),
        .commit (commit),
        .cfg    (cfg),
        .result (result),
        .state  (csr_state)
    );

    pipe_reg #(.payload_t(trap_out_t)) u_out_slice (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (id_valid),
        .in_ready  (res_ready),
        .in_data   (result),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

//--- verification/trap_unit_tb.sv
`default_nettype none

`include "exception_cause.svh"

module trap_unit_tb
    import rv_pkg::*;
    import trap_pkg::*;
();

    // Instruction kinds drawn by the stimulus generator
    localparam int K_ALU      = 0;
    localparam int K_IMM      = 1;
    localparam int K_LOAD     = 2;
    localparam int K_STORE    = 3;
    localparam int K_ECALL    = 4;
    localparam int K_MRET     = 5;
    localparam int K_RESERVED = 6;
    localparam int K_ZERO     = 7;

    localparam int PHASE1_LEN  = 64;
    localparam int PHASE2_LEN  = 96;
    localparam int PHASE3_LEN  = 64;
    localparam int TOTAL       = PHASE1_LEN + PHASE2_LEN + PHASE3_LEN;
    localparam int CYCLE_LIMIT = 20 * TOTAL + 100;

    localparam logic [XLEN-1:0] NO_TRAP_EPC = 32'h0001_0000;
    localparam logic [XLEN-1:0] MTVEC_RESET = 32'h0000_0100;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0]     LFSR_TAPS   = 32'h8020_0003;

    logic        clk = 1'b0;
    logic        rst;
    logic        in_valid;
    logic        in_ready;
    id_instr_t   in_data;
    logic        out_valid;
    logic        out_ready;
    trap_out_t   out_data;
    cfg_wr_t     cfg;
    trap_state_t csr_state;

    // Kind of the word now on in_data
    int          in_kind;
    logic [31:0] lfsr = 32'd95;

    // Reference model registers
    logic [XLEN-1:0] model_mepc   = '0;
    logic [XLEN-1:0] model_mcause = '0;
    logic [XLEN-1:0] model_mtval  = '0;
    logic [XLEN-1:0] model_mtvec  = MTVEC_RESET;

    // Expected results and CSR contents per accepted record
    trap_out_t   expected_q[$];
    trap_state_t state_hist[$];
    int          accept_cycle_q[$];

    int   cyc        = 0;
    int   taken      = 0;
    int   last_stall = -1;
    // Handshakes due at the coming rising edge
    logic in_xfer    = 1'b0;
    logic out_xfer   = 1'b0;

    trap_unit_top #(
        .NO_TRAP_EPC (NO_TRAP_EPC),
        .MTVEC_RESET (MTVEC_RESET)
    ) u_trap_unit_top (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .cfg       (cfg),
        .csr_state (csr_state)
    );

    always #4 clk = ~clk;

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return value;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp)
        else stop_on_error($sformatf("Fail %s: got 0x%08h expected 0x%08h", name, got, exp));
    endtask

    // Random instruction of a random kind with random PC and flags
    task automatic next_instr(output id_instr_t instr, output int kind);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [29:0] pc_word;
        kind    = int'(rand_bits(3));
        rd      = rand_bits(5);
        rs1     = rand_bits(5);
        rs2     = rand_bits(5);
        f3      = rand_bits(3);
        imm     = rand_bits(12);
        pc_word = rand_bits(30);
        case (kind)
            K_ALU:   instr.ir = {7'b0000000, rs2, rs1, f3, rd, OPCODE_OP};
            K_IMM:   instr.ir = {imm, rs1, 3'b000, rd, OPCODE_OP_IMM};
            // LW
            K_LOAD:  instr.ir = {imm, rs1, 3'b010, rd, OPCODE_LOAD};
            // SW
            K_STORE: instr.ir = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPCODE_STORE};
            K_ECALL: instr.ir = INSTR_ECALL;
            K_MRET:  instr.ir = INSTR_MRET;
            K_RESERVED:
            begin
                case (rand_bits(2))
                    // M extension is not part of the base set
                    0: instr.ir = {7'b0000001, rs2, rs1, f3, rd, OPCODE_OP};
                    1: instr.ir = {imm, rs1, 3'b111, rd, OPCODE_LOAD};
                    // custom-0 opcode
                    2: instr.ir = {imm, rs1, f3, rd, 7'b0001011};
                    // CSRRW mtvec is a SYSTEM word outside ECALL and MRET
                    default: instr.ir = {12'h305, rs1, 3'b001, rd, OPCODE_SYSTEM};
                endcase
            end
            default: instr.ir = '0;
        endcase
        instr.pc                = {pc_word, 2'b00};
        instr.i_addr_misaligned = (rand_bits(3) == 0);
        instr.jump              = (rand_bits(3) == 0);
    endtask

    // Reference model applied to records in acceptance order
    task automatic model_accept(input id_instr_t d, input int kind);
        cause_t    cause;
        trap_out_t exp;
        if (d.jump)
            cause = `NOT_EXCEPTION;
        else if (d.i_addr_misaligned)
            cause = `I_ADDR_MISALIGNMENT;
        else if (kind == K_RESERVED || kind == K_ZERO)
            cause = `ILLEGAL_IR;
        else if (kind == K_ECALL)
            cause = `ECALL;
        else
            cause = `NOT_EXCEPTION;
        exp.pc       = d.pc;
        exp.raised   = (cause != `NOT_EXCEPTION);
        exp.cause    = cause;
        exp.redirect = exp.raised || (kind == K_MRET && !d.jump);
        // Target uses mepc from all older records
        if (exp.raised)
            exp.target = model_mtvec;
        else if (exp.redirect)
            exp.target = model_mepc;
        else
            exp.target = '0;
        if (exp.raised)
        begin
            model_mepc = d.pc;
            case (cause)
                `I_ADDR_MISALIGNMENT:
                begin
                    model_mcause = 32'd0;
                    model_mtval  = d.pc;
                end
                `ILLEGAL_IR:
                begin
                    model_mcause = 32'd2;
                    model_mtval  = d.ir;
                end
                default:
                begin
                    model_mcause = 32'd11;
                    model_mtval  = '0;
                end
            endcase
        end
        expected_q.push_back(exp);
        state_hist.push_back(trap_state_t'{mepc: model_mepc, mcause: model_mcause,
                                           mtval: model_mtval, mtvec: model_mtvec});
        accept_cycle_q.push_back(cyc);
    endtask

    // Checks and model updates once per cycle at the falling edge
    always @(negedge clk)
    begin
        trap_out_t   exp_out;
        trap_state_t exp_state;
        int          committed;
        in_xfer  = 1'b0;
        out_xfer = 1'b0;
        assert (cyc < CYCLE_LIMIT)
        else stop_on_error($sformatf("Timeout: run not done after %0d cycles", CYCLE_LIMIT));
        if (!rst)
        begin
            assert (!(out_valid && expected_q.size() == 0))
            else stop_on_error("Output valid while no record is in flight");
            // Records that went into the output slice have updated the CSRs
            committed = taken + (out_valid ? 1 : 0);
            if (committed == 0)
                exp_state = '{mepc: '0, mcause: '0, mtval: '0, mtvec: MTVEC_RESET};
            else
                exp_state = state_hist[committed - 1];
            check_value("csr_state.mepc", csr_state.mepc, exp_state.mepc);
            check_value("csr_state.mcause", csr_state.mcause, exp_state.mcause);
            check_value("csr_state.mtval", csr_state.mtval, exp_state.mtval);
            check_value("csr_state.mtvec", csr_state.mtvec, model_mtvec);
            // Stalls only with both slices full and output blocked
            check_value("in_ready", in_ready, !(expected_q.size() == 2 && !out_ready));
            if (!out_ready)
                last_stall = cyc;
            out_xfer = out_valid && out_ready;
            if (out_xfer)
            begin
                exp_out = expected_q.pop_front();
                check_value("out_data.pc", out_data.pc, exp_out.pc);
                check_value("out_data.raised", out_data.raised, exp_out.raised);
                check_value("out_data.cause", out_data.cause, exp_out.cause);
                check_value("out_data.redirect", out_data.redirect, exp_out.redirect);
                check_value("out_data.target", out_data.target, exp_out.target);
                // No back-pressure since acceptance means fixed latency
                if (last_stall <= accept_cycle_q[0])
                    check_value("output latency", cyc - accept_cycle_q[0], 2);
                void'(accept_cycle_q.pop_front());
                taken++;
            end
            if (cfg.en)
                model_mtvec = cfg.data;
            in_xfer = in_valid && in_ready;
            if (in_xfer)
                model_accept(in_data, in_kind);
        end
        cyc++;
    end

    task automatic run_phase(input int count, input bit random_ready);
        id_instr_t instr;
        int        kind;
        int        issued;
        issued = 0;
        while (issued < count)
        begin
            @(posedge clk);
            out_ready <= random_ready ? (rand_bits(2) != 0) : 1'b1;
            // A record not yet taken stays on the bus unchanged
            if (!in_valid || in_xfer)
            begin
                if (rand_bits(2) != 0)
                begin
                    next_instr(instr, kind);
                    in_valid <= 1'b1;
                    in_data  <= instr;
                    in_kind  <= kind;
                    issued++;
                end
                else
                begin
                    in_valid <= 1'b0;
                end
            end
        end
        @(posedge clk);
        while (in_valid && !in_xfer)
        begin
            out_ready <= random_ready ? (rand_bits(2) != 0) : 1'b1;
            @(posedge clk);
        end
        in_valid <= 1'b0;
    endtask

    task automatic drain();
        while (expected_q.size() != 0)
        begin
            @(posedge clk);
            out_ready <= 1'b1;
        end
    endtask

    // New trap vector written while the pipeline is empty
    task automatic write_mtvec();
        logic [29:0] base;
        drain();
        base = rand_bits(30);
        @(posedge clk);
        cfg <= '{en: 1'b1, data: {base, 2'b00}};
        @(posedge clk);
        cfg <= '{en: 1'b0, data: '0};
    endtask

    initial
    begin
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_data   = '0;
        in_kind   = K_ALU;
        out_ready = 1'b1;
        cfg       = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        // Full rate first so every record gets the latency check
        run_phase(PHASE1_LEN, 1'b0);
        write_mtvec();
        run_phase(PHASE2_LEN, 1'b1);
        write_mtvec();
        run_phase(PHASE3_LEN, 1'b1);
        drain();
        repeat (3) @(posedge clk);
        if (taken == TOTAL && state_hist.size() == TOTAL)
        begin
            $display("TEST RESULT: PASS");
            $finish;
        end
        else
        begin
            stop_on_error($sformatf("Records lost: %0d accepted, %0d delivered, %0d planned",
                                    state_hist.size(), taken, TOTAL));
        end
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+include
hdl/rv_pkg.sv
hdl/trap_pkg.sv
hdl/pipe_reg.sv
hdl/instr_classifier.sv
hdl/exception_ctrl.sv
hdl/trap_csr.sv
hdl/trap_unit_top.sv
verification/trap_unit_tb.sv

//--- Bender.yml
package:
  name: trap_unit

export_include_dirs:
  - include

sources:
  - hdl/rv_pkg.sv
  - hdl/trap_pkg.sv
  - hdl/pipe_reg.sv
  - hdl/instr_classifier.sv
  - hdl/exception_ctrl.sv
  - hdl/trap_csr.sv
  - hdl/trap_unit_top.sv
  - target: test
    files:
      - verification/trap_unit_tb.sv
